// ==== Bender.yml ====
package:
  name: axi_dma_copy

sources:
  - verilog/dma_pkg.sv
  - verilog/dma_cmd_check.sv
  - verilog/dma_ctrl_fsm.sv
  - verilog/dma_req_gen.sv
  - verilog/dma_fifo.sv
  - verilog/axi_dma_copy.sv
  - target: simulation
    files:
      - verif/tb_axi_dma_copy.sv

// ==== flist.f ====
verilog/dma_pkg.sv
verilog/dma_cmd_check.sv
verilog/dma_ctrl_fsm.sv
verilog/dma_req_gen.sv
verilog/dma_fifo.sv
verilog/axi_dma_copy.sv
verif/tb_axi_dma_copy.sv

// ==== verif/tb_axi_dma_copy.sv ====
`timescale 1ns/100ps

module tb_axi_dma_copy
    import dma_pkg::*;
();

    localparam int FIFO_DEPTH = 32;
    localparam int MAX_BLOCK  = (FIFO_DEPTH * BC / 2 < AXI_BOUNDARY_BYTES) ?
                                FIFO_DEPTH * BC / 2 : AXI_BOUNDARY_BYTES;
    localparam int WAIT_LIMIT = 20000;

    logic      clk;
    logic      rst_n;
    logic      go_i;
    logic      flush_i;
    addr_t     src_addr_i;
    addr_t     dst_addr_i;
    byte_cnt_t byte_count_i;
    byte_cnt_t block_size_i;
    logic      rd_req_valid_o;
    logic      rd_req_ready_i;
    addr_t     rd_req_addr_o;
    req_len_t  rd_req_len_o;
    logic      rd_data_valid_i;
    logic      rd_data_ready_o;
    data_t     rd_data_i;
    logic      rd_resp_valid_i;
    axi_resp_t rd_resp_i;
    logic      wr_req_valid_o;
    logic      wr_req_ready_i;
    addr_t     wr_req_addr_o;
    req_len_t  wr_req_len_o;
    logic      wr_data_valid_o;
    logic      wr_data_ready_i;
    data_t     wr_data_o;
    logic      wr_resp_valid_i;
    axi_resp_t wr_resp_i;
    logic      busy_o;
    logic      done_o;
    logic      error_o;
    byte_cnt_t bytes_remaining_o;

    // Expected state of the running test
    string     cur_test;
    addr_t     cur_src;
    byte_cnt_t cur_count;
    byte_cnt_t cur_blk;
    addr_t     rd_exp_addr;
    byte_cnt_t rd_exp_left;
    addr_t     wr_exp_addr;
    byte_cnt_t wr_exp_left;
    int        rd_req_cnt;
    int        rd_err_idx;
    int        wr_data_cnt;
    logic      wr_stall;

    // Subordinate model state
    addr_t     rd_pend_addr [$];
    int        rd_pend_beats [$];
    bit        rd_pend_err [$];
    logic      rd_busy;
    addr_t     rd_cur_addr;
    int        rd_cur_left;
    bit        rd_cur_err;
    logic      rd_resp_due;
    bit        rd_resp_err;
    int        wr_pend_beats [$];
    int        wr_beats_seen;

    axi_dma_copy #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_axi_dma_copy (
        .clk              (clk),
        .rst_n            (rst_n),
        .go_i             (go_i),
        .flush_i          (flush_i),
        .src_addr_i       (src_addr_i),
        .dst_addr_i       (dst_addr_i),
        .byte_count_i     (byte_count_i),
        .block_size_i     (block_size_i),
        .rd_req_valid_o   (rd_req_valid_o),
        .rd_req_ready_i   (rd_req_ready_i),
        .rd_req_addr_o    (rd_req_addr_o),
        .rd_req_len_o     (rd_req_len_o),
        .rd_data_valid_i  (rd_data_valid_i),
        .rd_data_ready_o  (rd_data_ready_o),
        .rd_data_i        (rd_data_i),
        .rd_resp_valid_i  (rd_resp_valid_i),
        .rd_resp_i        (rd_resp_i),
        .wr_req_valid_o   (wr_req_valid_o),
        .wr_req_ready_i   (wr_req_ready_i),
        .wr_req_addr_o    (wr_req_addr_o),
        .wr_req_len_o     (wr_req_len_o),
        .wr_data_valid_o  (wr_data_valid_o),
        .wr_data_ready_i  (wr_data_ready_i),
        .wr_data_o        (wr_data_o),
        .wr_resp_valid_i  (wr_resp_valid_i),
        .wr_resp_i        (wr_resp_i),
        .busy_o           (busy_o),
        .done_o           (done_o),
        .error_o          (error_o),
        .bytes_remaining_o(bytes_remaining_o)
    );

    always #4 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            fail_now($sformatf("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act));
        end
    endtask

    task automatic check_len(input string what, input req_len_t exp, input req_len_t act);
        if (exp !== act) begin
            fail_now($sformatf("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act));
        end
    endtask

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (exp !== act) begin
            fail_now($sformatf("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input byte_cnt_t exp, input byte_cnt_t act);
        if (exp !== act) begin
            fail_now($sformatf("FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act));
        end
    endtask

    // Source memory contents, a fixed function of the whole address
    function automatic data_t src_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    // Next request size: stop at the block edge, the 4 KiB edge or the end
    function automatic byte_cnt_t ref_req_bytes(input addr_t addr, input byte_cnt_t left,
                                                input byte_cnt_t blk);
        byte_cnt_t block;
        byte_cnt_t size;
        if ((blk != 0) && (blk <= byte_cnt_t'(MAX_BLOCK))) begin
            block = blk;
        end else begin
            block = byte_cnt_t'(MAX_BLOCK);
        end
        size = block - (addr % block);
        if (byte_cnt_t'(AXI_BOUNDARY_BYTES) - (addr % AXI_BOUNDARY_BYTES) < size) begin
            size = byte_cnt_t'(AXI_BOUNDARY_BYTES) - (addr % AXI_BOUNDARY_BYTES);
        end
        if (left < size) begin
            size = left;
        end
        return size;
    endfunction

    function automatic bit ref_cmd_ok(input addr_t src, input addr_t dst,
                                      input byte_cnt_t count, input byte_cnt_t blk);
        bit ok;
        ok = (src % BC == 0) && (dst % BC == 0) && (count % BC == 0);
        ok = ok && (count <= byte_cnt_t'(MAX_XFER_BYTES));
        // Zero keeps the default block, otherwise a power of two of whole words
        ok = ok && ($countones(blk) <= 1) && (blk % BC == 0);
        return ok;
    endfunction

    // Read subordinate and read request checker
    always @(posedge clk) begin : rd_model
        byte_cnt_t exp_bytes;
        logic      beat_done;
        beat_done = 1'b0;
        if (rst_n) begin
            if (rd_req_valid_o && rd_req_ready_i) begin
                if (rd_exp_left == 0) begin
                    fail_now($sformatf("Unexpected read request in test %s", cur_test));
                end
                exp_bytes = ref_req_bytes(rd_exp_addr, rd_exp_left, cur_blk);
                check_addr("read request address", rd_exp_addr, rd_req_addr_o);
                check_len("read request length", req_len_t'(exp_bytes - BC), rd_req_len_o);
                rd_pend_addr.push_back(rd_req_addr_o);
                rd_pend_beats.push_back(int'(exp_bytes) / BC);
                rd_pend_err.push_back(rd_req_cnt == rd_err_idx);
                rd_req_cnt++;
                rd_exp_addr = rd_exp_addr + exp_bytes;
                rd_exp_left = rd_exp_left - exp_bytes;
            end
            beat_done = rd_data_valid_i && rd_data_ready_o;
            if (beat_done) begin
                rd_cur_addr = rd_cur_addr + addr_t'(BC);
                rd_cur_left--;
                if (rd_cur_left == 0) begin
                    rd_busy     = 1'b0;
                    rd_resp_due = 1'b1;
                    rd_resp_err = rd_cur_err;
                end
            end
        end
        #1;
        rd_resp_valid_i = rd_resp_due;
        rd_resp_i       = rd_resp_err ? AXI_RESP_SLVERR : axi_resp_t'(0);
        rd_resp_due     = 1'b0;
        if (!rd_busy && (rd_pend_addr.size() != 0)) begin
            rd_cur_addr = rd_pend_addr.pop_front();
            rd_cur_left = rd_pend_beats.pop_front();
            rd_cur_err  = rd_pend_err.pop_front();
            rd_busy     = 1'b1;
        end
        // A beat on offer stays until it is taken
        if (beat_done || !rd_data_valid_i) begin
            rd_data_valid_i = rd_busy && (($urandom % 4) != 0);
            rd_data_i       = rd_busy ? src_word(rd_cur_addr) : '0;
        end
        rd_req_ready_i = ($urandom % 3) != 0;
    end

    // Write subordinate, write request and write data checker
    always @(posedge clk) begin : wr_model
        byte_cnt_t exp_bytes;
        logic      stall_now;
        stall_now = wr_stall;
        if (rst_n) begin
            if (wr_req_valid_o && wr_req_ready_i) begin
                if (wr_exp_left == 0) begin
                    fail_now($sformatf("Unexpected write request in test %s", cur_test));
                end
                exp_bytes = ref_req_bytes(wr_exp_addr, wr_exp_left, cur_blk);
                check_addr("write request address", wr_exp_addr, wr_req_addr_o);
                check_len("write request length", req_len_t'(exp_bytes - BC), wr_req_len_o);
                wr_pend_beats.push_back(int'(exp_bytes) / BC);
                wr_exp_addr = wr_exp_addr + exp_bytes;
                wr_exp_left = wr_exp_left - exp_bytes;
            end
            if (wr_data_valid_o && wr_data_ready_i) begin
                if (wr_data_cnt >= int'(cur_count) / BC) begin
                    fail_now($sformatf("Extra write data beat in test %s", cur_test));
                end
                check_data("write data", src_word(cur_src + addr_t'(wr_data_cnt * BC)),
                           wr_data_o);
                wr_data_cnt++;
                wr_beats_seen++;
            end
        end
        #1;
        wr_resp_valid_i = 1'b0;
        // One response once all beats of the oldest request are in
        if ((wr_pend_beats.size() != 0) && (wr_beats_seen >= wr_pend_beats[0])) begin
            wr_beats_seen   = wr_beats_seen - wr_pend_beats.pop_front();
            wr_resp_valid_i = 1'b1;
        end
        wr_data_ready_i = !stall_now && (($urandom % 4) != 0);
    end

    task automatic run_copy(input string name, input addr_t src, input addr_t dst,
                            input byte_cnt_t count, input byte_cnt_t blk,
                            input int err_idx, input bit stall);
        bit cmd_ok;
        int n;
        cmd_ok      = ref_cmd_ok(src, dst, count, blk);
        cur_test    = name;
        cur_src     = src;
        cur_count   = count;
        cur_blk     = blk;
        rd_exp_addr = src;
        wr_exp_addr = dst;
        rd_exp_left = cmd_ok ? count : '0;
        wr_exp_left = cmd_ok ? count : '0;
        rd_req_cnt  = 0;
        wr_data_cnt = 0;
        rd_err_idx  = err_idx;
        wr_stall    = stall;

        src_addr_i   = src;
        dst_addr_i   = dst;
        byte_count_i = count;
        block_size_i = blk;
        go_i         = 1'b1;
        @(posedge clk);
        #1 go_i = 1'b0;

        if (stall) begin
            repeat (300) @(posedge clk);
            if (rd_data_ready_o || done_o) begin
                fail_now($sformatf("FIFO did not fill under write back-pressure in %s", name));
            end
            #1 wr_stall = 1'b0;
        end

        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_now($sformatf("Timed out waiting for done or error in test %s", name));
            end
        end while (!done_o && !error_o);

        if (!cmd_ok || (err_idx >= 0)) begin
            if (done_o) begin
                fail_now($sformatf("Test %s completed although an error was due", name));
            end
            #1;
            if (cmd_ok) begin
                check_count("bytes drained before error", count,
                            byte_cnt_t'(wr_data_cnt * BC));
            end
            flush_i = 1'b1;
            @(posedge clk);
            #1 flush_i = 1'b0;
            @(posedge clk);
            if (busy_o || error_o) begin
                fail_now($sformatf("DUT did not return to idle after flush in %s", name));
            end
        end else begin
            if (error_o) begin
                fail_now($sformatf("Test %s ended in error instead of done", name));
            end
            check_count("bytes remaining at done", '0, bytes_remaining_o);
            #1;
            check_count("read bytes never requested", '0, rd_exp_left);
            check_count("write bytes never requested", '0, wr_exp_left);
            check_count("bytes written", count, byte_cnt_t'(wr_data_cnt * BC));
            @(posedge clk);
            if (done_o || busy_o) begin
                fail_now($sformatf("done_o longer than one cycle or still busy in %s", name));
            end
        end
        #1;
    endtask

    initial begin : main
        addr_t     src;
        addr_t     dst;
        byte_cnt_t count;
        byte_cnt_t blk;
        byte_cnt_t blk_choice [5];
        void'($urandom(32'h486f_ddf6));
        blk_choice[0] = 0;
        blk_choice[1] = 16;
        blk_choice[2] = 32;
        blk_choice[3] = 64;
        blk_choice[4] = 256;

        clk             = 1'b0;
        rst_n           = 1'b0;
        go_i            = 1'b0;
        flush_i         = 1'b0;
        src_addr_i      = '0;
        dst_addr_i      = '0;
        byte_count_i    = '0;
        block_size_i    = '0;
        rd_req_ready_i  = 1'b0;
        rd_data_valid_i = 1'b0;
        rd_data_i       = '0;
        rd_resp_valid_i = 1'b0;
        rd_resp_i       = '0;
        wr_req_ready_i  = 1'b1;
        wr_data_ready_i = 1'b0;
        wr_resp_valid_i = 1'b0;
        wr_resp_i       = '0;
        wr_stall        = 1'b0;
        rd_busy         = 1'b0;
        rd_resp_due     = 1'b0;
        rd_resp_err     = 1'b0;
        wr_beats_seen   = 0;
        rd_err_idx      = -1;
        rd_exp_left     = '0;
        wr_exp_left     = '0;
        cur_test        = "reset";

        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        if (busy_o || done_o || error_o || rd_req_valid_o || wr_req_valid_o ||
            wr_data_valid_o || !rd_data_ready_o) begin
            fail_now("Outputs are not idle after reset");
        end

        run_copy("zero_length", 32'h0000_1000, 32'h0000_2000, 0, 0, -1, 1'b0);
        run_copy("cross_4k", 32'h0000_0fe8, 32'h2000_1ff4, 200, 0, -1, 1'b0);

        for (int i = 0; i < 12; i++) begin
            src   = addr_t'($urandom) & 32'h7fff_fffc;
            dst   = addr_t'($urandom) & 32'h7fff_fffc;
            count = byte_cnt_t'(($urandom % 384) * BC);
            blk   = blk_choice[$urandom % 5];
            run_copy($sformatf("random_%0d", i), src, dst, count, blk, -1, 1'b0);
        end

        run_copy("wr_backpressure", 32'h0004_0000, 32'h0008_0100, 1024, 0, -1, 1'b1);
        run_copy("rd_slverr", 32'h0000_3000, 32'h0000_5000, 256, 32, 2, 1'b0);

        // Malformed commands
        run_copy("bad_src_align", 32'h0000_1002, 32'h0000_2000, 64, 0, -1, 1'b0);
        run_copy("bad_count_align", 32'h0000_1000, 32'h0000_2000, 66, 0, -1, 1'b0);
        run_copy("count_too_big", 32'h0000_1000, 32'h0000_2000, 32'h0010_0004, 0, -1, 1'b0);
        run_copy("block_not_pow2", 32'h0000_1000, 32'h0000_2000, 64, 48, -1, 1'b0);
        run_copy("block_below_word", 32'h0000_1000, 32'h0000_2000, 64, 2, -1, 1'b0);

        run_copy("after_errors", 32'h0001_0ff0, 32'h0003_0000, 160, 16, -1, 1'b0);

        $display("Test passed");
        $finish;
    end

endmodule

// ==== verilog/axi_dma_copy.sv ====
`timescale 1ns/100ps

module axi_dma_copy
    import dma_pkg::*;
#(
    parameter int FIFO_DEPTH = 32
) (
    input  logic      clk,
    input  logic      rst_n,

    // Command
    input  logic      go_i,
    input  logic      flush_i,
    input  addr_t     src_addr_i,
    input  addr_t     dst_addr_i,
    input  byte_cnt_t byte_count_i,
    input  byte_cnt_t block_size_i,

    // Read requests, data and responses
    output logic      rd_req_valid_o,
    input  logic      rd_req_ready_i,
    output addr_t     rd_req_addr_o,
    output req_len_t  rd_req_len_o,
    input  logic      rd_data_valid_i,
    output logic      rd_data_ready_o,
    input  data_t     rd_data_i,
    input  logic      rd_resp_valid_i,
    input  axi_resp_t rd_resp_i,

    // Write requests, data and responses
    output logic      wr_req_valid_o,
    input  logic      wr_req_ready_i,
    output addr_t     wr_req_addr_o,
    output req_len_t  wr_req_len_o,
    output logic      wr_data_valid_o,
    input  logic      wr_data_ready_i,
    output data_t     wr_data_o,
    input  logic      wr_resp_valid_i,
    input  axi_resp_t wr_resp_i,

    // Status
    output logic      busy_o,
    output logic      done_o,
    output logic      error_o,
    output byte_cnt_t bytes_remaining_o
);

    logic       cmd_error;
    dma_state_e state;
    logic       active;
    logic       fifo_clr;
    logic       fifo_push;
    logic       fifo_pop;
    logic       wr_req_accept;

    assign active        = (state == DMA_WAIT_DATA);
    assign busy_o        = (state != DMA_IDLE);
    // Leftover data is only dropped once the engine is back in idle
    assign fifo_clr      = (state == DMA_IDLE) && flush_i;
    assign fifo_push     = rd_data_valid_i && rd_data_ready_o;
    assign fifo_pop      = wr_data_valid_o && wr_data_ready_i;
    assign wr_req_accept = wr_req_valid_o && wr_req_ready_i;

    dma_cmd_check i_dma_cmd_check (
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .byte_count_i(byte_count_i),
        .block_size_i(block_size_i),
        .cmd_error_o (cmd_error)
    );

    dma_ctrl_fsm i_dma_ctrl_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .go_i             (go_i),
        .flush_i          (flush_i),
        .cmd_error_i      (cmd_error),
        .byte_count_i     (byte_count_i),
        .fifo_pop_i       (fifo_pop),
        .wr_req_accept_i  (wr_req_accept),
        .wr_resp_valid_i  (wr_resp_valid_i),
        .wr_resp_i        (wr_resp_i),
        .rd_resp_valid_i  (rd_resp_valid_i),
        .rd_resp_i        (rd_resp_i),
        .state_o          (state),
        .bytes_remaining_o(bytes_remaining_o),
        .done_o           (done_o),
        .error_o          (error_o)
    );

    // Read side starts with the whole FIFO as credit, pops return it
    dma_req_gen #(
        .FIFO_DEPTH       (FIFO_DEPTH),
        .CREDIT_START_FULL(1'b1)
    ) i_rd_req_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .active_i       (active),
        .base_addr_i    (src_addr_i),
        .byte_count_i   (byte_count_i),
        .block_size_i   (block_size_i),
        .credit_return_i(fifo_pop),
        .req_ready_i    (rd_req_ready_i),
        .req_valid_o    (rd_req_valid_o),
        .req_addr_o     (rd_req_addr_o),
        .req_len_o      (rd_req_len_o)
    );

    // Write side only asks for data that has already landed
    dma_req_gen #(
        .FIFO_DEPTH       (FIFO_DEPTH),
        .CREDIT_START_FULL(1'b0)
    ) i_wr_req_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .active_i       (active),
        .base_addr_i    (dst_addr_i),
        .byte_count_i   (byte_count_i),
        .block_size_i   (block_size_i),
        .credit_return_i(fifo_push),
        .req_ready_i    (wr_req_ready_i),
        .req_valid_o    (wr_req_valid_o),
        .req_addr_o     (wr_req_addr_o),
        .req_len_o      (wr_req_len_o)
    );

    dma_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_dma_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .clr_i       (fifo_clr),
        .push_valid_i(rd_data_valid_i),
        .push_data_i (rd_data_i),
        .push_ready_o(rd_data_ready_o),
        .pop_valid_o (wr_data_valid_o),
        .pop_ready_i (wr_data_ready_i),
        .pop_data_o  (wr_data_o)
    );

endmodule

// ==== verilog/dma_cmd_check.sv ====
`timescale 1ns/100ps

module dma_cmd_check
    import dma_pkg::*;
(
    input  addr_t     src_addr_i,
    input  addr_t     dst_addr_i,
    input  byte_cnt_t byte_count_i,
    input  byte_cnt_t block_size_i,
    output logic      cmd_error_o
);

    logic inv_src_addr;
    logic inv_dst_addr;
    logic inv_byte_count;
    logic inv_block_size;

    always_comb begin
        // Both addresses must be word aligned
        inv_src_addr = |src_addr_i[BW-1:0];
        inv_dst_addr = |dst_addr_i[BW-1:0];

        // Whole words only, and no more than the transfer limit
        inv_byte_count = (|byte_count_i[BW-1:0]) ||
                         (byte_count_i > byte_cnt_t'(MAX_XFER_BYTES));

        // Zero selects the default block, anything else is a power of two
        inv_block_size = (|(block_size_i & (block_size_i - byte_cnt_t'(1)))) ||
                         (|block_size_i[BW-1:0]);

        cmd_error_o = inv_src_addr   ||
                      inv_dst_addr   ||
                      inv_byte_count ||
                      inv_block_size;
    end

endmodule

// ==== verilog/dma_ctrl_fsm.sv ====
`timescale 1ns/100ps

module dma_ctrl_fsm
    import dma_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       go_i,
    input  logic       flush_i,
    input  logic       cmd_error_i,
    input  byte_cnt_t  byte_count_i,
    input  logic       fifo_pop_i,
    input  logic       wr_req_accept_i,
    input  logic       wr_resp_valid_i,
    input  axi_resp_t  wr_resp_i,
    input  logic       rd_resp_valid_i,
    input  axi_resp_t  rd_resp_i,
    output dma_state_e state_o,
    output byte_cnt_t  bytes_remaining_o,
    output logic       done_o,
    output logic       error_o
);

    dma_state_e state_q;
    dma_state_e state_d;
    byte_cnt_t  bytes_remaining_q;
    logic [3:0] wr_resp_pending;
    logic       axi_error;
    logic       resp_error;
    logic       xfer_complete;

    always_comb begin
        resp_error = (rd_resp_valid_i && (rd_resp_i inside {AXI_RESP_SLVERR, AXI_RESP_DECERR})) ||
                     (wr_resp_valid_i && (wr_resp_i inside {AXI_RESP_SLVERR, AXI_RESP_DECERR}));
        // Every beat has left the FIFO and every write has been answered
        xfer_complete = (bytes_remaining_q == '0) && (wr_resp_pending == '0);
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            DMA_IDLE: begin
                if (go_i) begin
                    state_d = cmd_error_i ? DMA_ERROR : DMA_WAIT_DATA;
                end
            end
            DMA_WAIT_DATA: begin
                if (xfer_complete) begin
                    state_d = axi_error ? DMA_ERROR : DMA_DONE;
                end
            end
            DMA_DONE: begin
                state_d = DMA_IDLE;
            end
            DMA_ERROR: begin
                if (flush_i) begin
                    state_d = DMA_IDLE;
                end
            end
            default: begin
                state_d = DMA_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q           <= DMA_IDLE;
            bytes_remaining_q <= '0;
            wr_resp_pending   <= '0;
            axi_error         <= 1'b0;
        end else begin
            state_q <= state_d;

            // Counts down as beats reach the write side
            if ((state_q == DMA_IDLE) && go_i) begin
                bytes_remaining_q <= byte_count_i;
            end else if (fifo_pop_i) begin
                bytes_remaining_q <= bytes_remaining_q - byte_cnt_t'(BC);
            end

            if (state_q == DMA_IDLE) begin
                wr_resp_pending <= '0;
            end else if (wr_req_accept_i && !wr_resp_valid_i) begin
                wr_resp_pending <= wr_resp_pending + 4'd1;
            end else if (!wr_req_accept_i && wr_resp_valid_i) begin
                wr_resp_pending <= wr_resp_pending - 4'd1;
            end

            if ((state_q == DMA_IDLE) || flush_i) begin
                axi_error <= 1'b0;
            end else if (resp_error) begin
                axi_error <= 1'b1;
            end
        end
    end

    assign state_o           = state_q;
    assign bytes_remaining_o = bytes_remaining_q;
    assign done_o            = (state_q == DMA_DONE);
    assign error_o           = (state_q == DMA_ERROR);

    // The subordinate must never answer more writes than were issued,
    // and no more than 15 writes may wait for an answer
    a_wr_resp_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q != DMA_IDLE) |->
            !((wr_resp_pending == 4'hF) && wr_req_accept_i && !wr_resp_valid_i) &&
            !((wr_resp_pending == 4'h0) && wr_resp_valid_i && !wr_req_accept_i));

endmodule

// ==== verilog/dma_fifo.sv ====
`timescale 1ns/100ps

module dma_fifo
    import dma_pkg::*;
#(
    parameter int FIFO_DEPTH = 32
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clr_i,
    input  logic  push_valid_i,
    input  data_t push_data_i,
    output logic  push_ready_o,
    output logic  pop_valid_o,
    input  logic  pop_ready_i,
    output data_t pop_data_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    data_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push_ready_o = (count != CNT_W'(FIFO_DEPTH));
    assign pop_valid_o  = (count != '0);
    assign pop_data_o   = mem[rd_ptr];
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // Read credits reserve a slot for every requested beat
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_valid_i |-> push_ready_o);

endmodule

// ==== verilog/dma_pkg.sv ====
package dma_pkg;

    // Data path geometry
    localparam int DATA_W = 32;
    localparam int BC     = DATA_W / 8;
    localparam int BW     = $clog2(BC);

    localparam int ADDR_W = 32;

    // A request byte count must be able to hold a full 4 KiB
    localparam int AXI_LEN_BC_W       = 13;
    localparam int AXI_BOUNDARY_BYTES = 4096;

    // Largest legal transfer, 1 MiB
    localparam int MAX_XFER_BYTES = 32'h0010_0000;

    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [DATA_W-1:0]       data_t;
    typedef logic [31:0]             byte_cnt_t;
    typedef logic [AXI_LEN_BC_W-1:0] req_len_t;
    typedef logic [1:0]              axi_resp_t;

    localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;
    localparam axi_resp_t AXI_RESP_DECERR = 2'b11;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_WAIT_DATA,
        DMA_DONE,
        DMA_ERROR
    } dma_state_e;

endpackage

// ==== verilog/dma_req_gen.sv ====
`timescale 1ns/100ps

module dma_req_gen
    import dma_pkg::*;
#(
    parameter int FIFO_DEPTH        = 32,
    parameter bit CREDIT_START_FULL = 1'b0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      active_i,
    input  addr_t     base_addr_i,
    input  byte_cnt_t byte_count_i,
    input  byte_cnt_t block_size_i,
    input  logic      credit_return_i,
    input  logic      req_ready_i,
    output logic      req_valid_o,
    output addr_t     req_addr_o,
    output req_len_t  req_len_o
);

    localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);
    localparam int FIFO_BYTES = FIFO_DEPTH * BC;
    localparam int BOUND_W    = $clog2(AXI_BOUNDARY_BYTES);
    // Half the FIFO keeps both channels busy, capped at the AXI 4 KiB limit
    localparam int MAX_BLOCK_SIZE = (FIFO_BYTES / 2 < AXI_BOUNDARY_BYTES) ?
                                    FIFO_BYTES / 2 : AXI_BOUNDARY_BYTES;
    localparam logic [CREDIT_W-1:0] CREDIT_START = CREDIT_START_FULL ?
                                                   CREDIT_W'(FIFO_DEPTH) : '0;

    byte_cnt_t           bytes_requested;
    byte_cnt_t           bytes_left;
    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] req_beats;
    req_len_t            block_bytes;
    req_len_t            blk_offset;
    req_len_t            align_bytes;
    req_len_t            req_bytes;
    logic                req_accept;
    addr_t               req_last_addr;

    always_comb begin
        // Oversized or zero block size falls back to the largest block
        if ((block_size_i != '0) && (block_size_i <= byte_cnt_t'(MAX_BLOCK_SIZE))) begin
            block_bytes = req_len_t'(block_size_i);
        end else begin
            block_bytes = req_len_t'(MAX_BLOCK_SIZE);
        end

        // Distance to the next block boundary, which also lies on a 4 KiB line
        blk_offset  = req_addr_o[AXI_LEN_BC_W-1:0] & (block_bytes - req_len_t'(1));
        align_bytes = block_bytes - blk_offset;

        bytes_left = byte_count_i - bytes_requested;
        if (bytes_left < byte_cnt_t'(align_bytes)) begin
            req_bytes = req_len_t'(bytes_left);
        end else begin
            req_bytes = align_bytes;
        end
        req_beats = CREDIT_W'(req_bytes[AXI_LEN_BC_W-1:BW]);
    end

    assign req_addr_o    = base_addr_i + bytes_requested;
    assign req_len_o     = req_bytes - req_len_t'(BC);
    assign req_valid_o   = active_i &&
                           (bytes_requested < byte_count_i) &&
                           (credits >= req_beats);
    assign req_accept    = req_valid_o && req_ready_i;
    assign req_last_addr = req_addr_o + addr_t'(req_len_o);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bytes_requested <= '0;
            credits         <= CREDIT_START;
        end else if (!active_i) begin
            bytes_requested <= '0;
            credits         <= CREDIT_START;
        end else begin
            if (req_accept) begin
                bytes_requested <= bytes_requested + byte_cnt_t'(req_bytes);
            end
            // One word back per FIFO strobe, a whole request out per accept
            credits <= credits + CREDIT_W'(credit_return_i) -
                       (req_accept ? req_beats : '0);
        end
    end

    // Credits mirror FIFO space, so they can never exceed its depth
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CREDIT_W'(FIFO_DEPTH));

    a_req_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        req_accept |-> (req_bytes <= req_len_t'(MAX_BLOCK_SIZE)) &&
            (req_addr_o[ADDR_W-1:BOUND_W] == req_last_addr[ADDR_W-1:BOUND_W]));

endmodule
